// ==== hdl/plic_defs.svh ====
`ifndef PLIC_DEFS_SVH
`define PLIC_DEFS_SVH

// Sizes
`define PLIC_SOURCE_COUNT       2
`define PLIC_TARGET_COUNT       2
`define PLIC_PRIO_WIDTH         3
`define PLIC_SOURCE_WIDTH       2

// Bus geometry
`define PLIC_REG_OFFSET_WIDTH   24
`define XLEN                    32

// ------------------------------------------------------------
// Register map offsets, low 24 address bits
// ------------------------------------------------------------

// Priority word per source, source 0 sits at the base and is reserved
`define PLIC_OFS_PRIO_BASE      24'h000000
`define PLIC_OFS_PENDING        24'h001000

// One enable word per target
`define PLIC_OFS_IE_BASE        24'h002000
`define PLIC_OFS_IE_STRIDE      24'h000080

// Per-target context holds threshold then claim/complete
`define PLIC_OFS_TH_BASE        24'h200000
`define PLIC_OFS_CTX_STRIDE     24'h001000
`define PLIC_OFS_CLAIM          24'h000004

`endif

// ==== hdl/plic_bus_pkg.sv ====
`include "plic_defs.svh"

package plic_bus_pkg;

    // Full bus address, only the low offset bits are decoded
    typedef logic [31:0] bus_addr_t;

    // Read and write data word
    typedef logic [`XLEN-1:0] bus_data_t;

endpackage

// ==== hdl/plic_irq_pkg.sv ====
`include "plic_defs.svh"

package plic_irq_pkg;

    // Source priority, also used for target thresholds
    typedef logic [`PLIC_PRIO_WIDTH-1:0] prio_t;

    // Source number, 0 means no source
    typedef logic [`PLIC_SOURCE_WIDTH-1:0] src_idx_t;

    // One bit per real source, bit 0 is source 1
    typedef logic [`PLIC_SOURCE_COUNT-1:0] src_mask_t;

endpackage

// ==== hdl/plic_regs.sv ====
`timescale 1ns/10ps

`include "plic_defs.svh"

module plic_regs (
    input  logic                                             clk,
    input  logic                                             rst_n,

    // Data bus slave port
    input  logic                                             bus_cyc_i,
    input  logic                                             bus_we_i,
    input  plic_bus_pkg::bus_addr_t                          bus_addr_i,
    input  plic_bus_pkg::bus_data_t                          bus_wdata_i,
    input  logic                                             plic_sel_i,
    output plic_bus_pkg::bus_data_t                          bus_rdata_o,
    output logic                                             bus_ack_o,

    // Gateway and target side
    input  plic_irq_pkg::src_mask_t                          pending_i,
    input  plic_irq_pkg::src_idx_t  [`PLIC_TARGET_COUNT-1:0] claim_idx_i,
    output plic_irq_pkg::src_mask_t [`PLIC_TARGET_COUNT-1:0] ie_o,
    output plic_irq_pkg::prio_t     [`PLIC_SOURCE_COUNT-1:0] prio_o,
    output plic_irq_pkg::prio_t     [`PLIC_TARGET_COUNT-1:0] prio_th_o,
    output logic                    [`PLIC_TARGET_COUNT-1:0] claim_req_o,
    output logic                    [`PLIC_TARGET_COUNT-1:0] complete_req_o,
    output plic_irq_pkg::src_idx_t  [`PLIC_TARGET_COUNT-1:0] complete_idx_o
);

    import plic_bus_pkg::*;
    import plic_irq_pkg::*;

    localparam int OFS_W = `PLIC_REG_OFFSET_WIDTH;
    typedef logic [OFS_W-1:0] ofs_t;

    ofs_t       reg_addr;
    logic       reg_rd_req;
    logic       reg_wr_req;
    bus_data_t  reg_r_data;
    bus_data_t  rdata_q;
    logic       ack_q;

    // Programmable state
    prio_t     [`PLIC_SOURCE_COUNT-1:0] prio_q;
    src_mask_t [`PLIC_TARGET_COUNT-1:0] ie_q;
    prio_t     [`PLIC_TARGET_COUNT-1:0] th_q;

    logic [`PLIC_SOURCE_COUNT-1:0] prio_wr;
    logic [`PLIC_TARGET_COUNT-1:0] ie_wr;
    logic [`PLIC_TARGET_COUNT-1:0] th_wr;

    // Offsets for zero-based real source s and target t
    function automatic ofs_t prio_ofs(int s);
        return ofs_t'(`PLIC_OFS_PRIO_BASE + 4 * (s + 1));
    endfunction

    function automatic ofs_t ie_ofs(int t);
        return ofs_t'(`PLIC_OFS_IE_BASE + t * `PLIC_OFS_IE_STRIDE);
    endfunction

    function automatic ofs_t th_ofs(int t);
        return ofs_t'(`PLIC_OFS_TH_BASE + t * `PLIC_OFS_CTX_STRIDE);
    endfunction

    function automatic ofs_t claim_ofs(int t);
        return ofs_t'(`PLIC_OFS_TH_BASE + t * `PLIC_OFS_CTX_STRIDE + `PLIC_OFS_CLAIM);
    endfunction

    assign reg_addr   = bus_addr_i[OFS_W-1:0];
    assign reg_rd_req = bus_cyc_i & plic_sel_i & ~bus_we_i;
    assign reg_wr_req = bus_cyc_i & plic_sel_i & bus_we_i;

    // ------------------------------------------------------------
    // Read decode
    // ------------------------------------------------------------
    // Unmatched offsets and reserved source 0 read as zero
    always_comb begin
        reg_r_data  = '0;
        claim_req_o = '0;
        if (reg_rd_req) begin
            if (reg_addr == ofs_t'(`PLIC_OFS_PENDING)) begin
                reg_r_data[`PLIC_SOURCE_COUNT:1] = pending_i;
            end
            for (int s = 0; s < `PLIC_SOURCE_COUNT; s++) begin
                if (reg_addr == prio_ofs(s)) begin
                    reg_r_data[`PLIC_PRIO_WIDTH-1:0] = prio_q[s];
                end
            end
            for (int t = 0; t < `PLIC_TARGET_COUNT; t++) begin
                if (reg_addr == ie_ofs(t)) begin
                    reg_r_data[`PLIC_SOURCE_COUNT:1] = ie_q[t];
                end
                if (reg_addr == th_ofs(t)) begin
                    reg_r_data[`PLIC_PRIO_WIDTH-1:0] = th_q[t];
                end
                // Reading the claim word is the claim itself
                if (reg_addr == claim_ofs(t)) begin
                    reg_r_data[`PLIC_SOURCE_WIDTH-1:0] = claim_idx_i[t];
                    claim_req_o[t] = 1'b1;
                end
            end
        end
    end

    // ------------------------------------------------------------
    // Write decode
    // ------------------------------------------------------------
    always_comb begin
        prio_wr        = '0;
        ie_wr          = '0;
        th_wr          = '0;
        complete_req_o = '0;
        complete_idx_o = '0;
        if (reg_wr_req) begin
            for (int s = 0; s < `PLIC_SOURCE_COUNT; s++) begin
                prio_wr[s] = (reg_addr == prio_ofs(s));
            end
            for (int t = 0; t < `PLIC_TARGET_COUNT; t++) begin
                ie_wr[t] = (reg_addr == ie_ofs(t));
                th_wr[t] = (reg_addr == th_ofs(t));
                if (reg_addr == claim_ofs(t)) begin
                    complete_req_o[t] = 1'b1;
                    complete_idx_o[t] = bus_wdata_i[`PLIC_SOURCE_WIDTH-1:0];
                end
            end
        end
    end

    // Register update truncates written values to field width
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prio_q <= '0;
            ie_q   <= '0;
            th_q   <= '0;
        end else begin
            for (int s = 0; s < `PLIC_SOURCE_COUNT; s++) begin
                if (prio_wr[s]) begin
                    prio_q[s] <= bus_wdata_i[`PLIC_PRIO_WIDTH-1:0];
                end
            end
            for (int t = 0; t < `PLIC_TARGET_COUNT; t++) begin
                if (ie_wr[t]) begin
                    ie_q[t] <= bus_wdata_i[`PLIC_SOURCE_COUNT:1];
                end
                if (th_wr[t]) begin
                    th_q[t] <= bus_wdata_i[`PLIC_PRIO_WIDTH-1:0];
                end
            end
        end
    end

    // ------------------------------------------------------------
    // Bus response
    // ------------------------------------------------------------
    // A held read acks every other cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= reg_rd_req & ~ack_q;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdata_q <= '0;
        end else if (reg_rd_req && !ack_q) begin
            rdata_q <= reg_r_data;
        end
    end

    assign bus_rdata_o = rdata_q;
    assign bus_ack_o   = reg_wr_req | ack_q;   // writes ack in the same cycle

    assign ie_o      = ie_q;
    assign prio_o    = prio_q;
    assign prio_th_o = th_q;

endmodule

// ==== hdl/plic_gateway.sv ====
`timescale 1ns/10ps

`include "plic_defs.svh"

module plic_gateway (
    input  logic                                            clk,
    input  logic                                            rst_n,
    input  plic_irq_pkg::src_mask_t                         irq_src_i,
    input  logic                   [`PLIC_TARGET_COUNT-1:0] claim_req_i,
    input  logic                   [`PLIC_TARGET_COUNT-1:0] complete_req_i,
    input  plic_irq_pkg::src_idx_t [`PLIC_TARGET_COUNT-1:0] complete_idx_i,
    input  plic_irq_pkg::src_idx_t [`PLIC_TARGET_COUNT-1:0] claim_idx_i,
    output plic_irq_pkg::src_mask_t                         pending_o
);

    import plic_irq_pkg::*;

    src_mask_t pending_q;
    src_mask_t in_service_q;
    src_mask_t claim_hit;
    src_mask_t complete_hit;

    // Collect claims and completions from all targets per source
    always_comb begin
        claim_hit    = '0;
        complete_hit = '0;
        for (int t = 0; t < `PLIC_TARGET_COUNT; t++) begin
            for (int s = 0; s < `PLIC_SOURCE_COUNT; s++) begin
                if (claim_req_i[t] && claim_idx_i[t] == src_idx_t'(s + 1)) begin
                    claim_hit[s] = 1'b1;
                end
                if (complete_req_i[t] && complete_idx_i[t] == src_idx_t'(s + 1)) begin
                    complete_hit[s] = 1'b1;
                end
            end
        end
    end

    // Level sources latch only while not in service
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending_q    <= '0;
            in_service_q <= '0;
        end else begin
            pending_q    <= (pending_q | (irq_src_i & ~in_service_q)) & ~claim_hit;
            in_service_q <= (in_service_q | claim_hit) & ~complete_hit;
        end
    end

    assign pending_o = pending_q;

endmodule

// ==== hdl/plic_target.sv ====
`timescale 1ns/10ps

`include "plic_defs.svh"

module plic_target (
    input  plic_irq_pkg::src_mask_t                          pending_i,
    input  plic_irq_pkg::src_mask_t [`PLIC_TARGET_COUNT-1:0] ie_i,
    input  plic_irq_pkg::prio_t     [`PLIC_SOURCE_COUNT-1:0] prio_i,
    input  plic_irq_pkg::prio_t     [`PLIC_TARGET_COUNT-1:0] prio_th_i,
    output plic_irq_pkg::src_idx_t  [`PLIC_TARGET_COUNT-1:0] claim_idx_o,
    output logic                    [`PLIC_TARGET_COUNT-1:0] irq_o
);

    import plic_irq_pkg::*;

    // ------------------------------------------------------------
    // Best-source search per target
    // ------------------------------------------------------------
    always_comb begin
        prio_t    best_prio;
        src_idx_t best_idx;

        claim_idx_o = '0;
        irq_o       = '0;
        for (int t = 0; t < `PLIC_TARGET_COUNT; t++) begin
            best_prio = '0;
            best_idx  = '0;
            // Strict compare keeps the lower source number on a tie
            for (int s = 0; s < `PLIC_SOURCE_COUNT; s++) begin
                if (pending_i[s] && ie_i[t][s] &&
                    (best_idx == '0 || prio_i[s] > best_prio)) begin
                    best_prio = prio_i[s];
                    best_idx  = src_idx_t'(s + 1);
                end
            end

            // Only a source strictly above threshold is offered
            if (best_idx != '0 && best_prio > prio_th_i[t]) begin
                claim_idx_o[t] = best_idx;
            end
            irq_o[t] = (claim_idx_o[t] != '0);
        end
    end

endmodule

// ==== hdl/plic_top.sv ====
`timescale 1ns/10ps

`include "plic_defs.svh"

module plic_top (
    input  logic                                   clk,
    input  logic                                   rst_n,

    // Data bus slave port
    input  logic                                   bus_cyc_i,
    input  logic                                   bus_we_i,
    input  plic_bus_pkg::bus_addr_t                bus_addr_i,
    input  plic_bus_pkg::bus_data_t                bus_wdata_i,
    input  logic                                   plic_sel_i,
    output plic_bus_pkg::bus_data_t                bus_rdata_o,
    output logic                                   bus_ack_o,

    // Interrupt lines
    input  plic_irq_pkg::src_mask_t                irq_src_i,
    output logic          [`PLIC_TARGET_COUNT-1:0] irq_o
);

    import plic_irq_pkg::*;

    src_mask_t [`PLIC_TARGET_COUNT-1:0] ie;
    prio_t     [`PLIC_SOURCE_COUNT-1:0] prio;
    prio_t     [`PLIC_TARGET_COUNT-1:0] prio_th;
    src_mask_t                          pending;
    src_idx_t  [`PLIC_TARGET_COUNT-1:0] claim_idx;
    src_idx_t  [`PLIC_TARGET_COUNT-1:0] complete_idx;
    logic      [`PLIC_TARGET_COUNT-1:0] claim_req;
    logic      [`PLIC_TARGET_COUNT-1:0] complete_req;

    plic_regs plic_regs_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .bus_cyc_i      (bus_cyc_i),
        .bus_we_i       (bus_we_i),
        .bus_addr_i     (bus_addr_i),
        .bus_wdata_i    (bus_wdata_i),
        .plic_sel_i     (plic_sel_i),
        .bus_rdata_o    (bus_rdata_o),
        .bus_ack_o      (bus_ack_o),
        .pending_i      (pending),
        .claim_idx_i    (claim_idx),
        .ie_o           (ie),
        .prio_o         (prio),
        .prio_th_o      (prio_th),
        .claim_req_o    (claim_req),
        .complete_req_o (complete_req),
        .complete_idx_o (complete_idx)
    );

    plic_gateway plic_gateway_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .irq_src_i      (irq_src_i),
        .claim_req_i    (claim_req),
        .complete_req_i (complete_req),
        .complete_idx_i (complete_idx),
        .claim_idx_i    (claim_idx),
        .pending_o      (pending)
    );

    plic_target plic_target_i (
        .pending_i      (pending),
        .ie_i           (ie),
        .prio_i         (prio),
        .prio_th_i      (prio_th),
        .claim_idx_o    (claim_idx),
        .irq_o          (irq_o)
    );

endmodule

// ==== tests/tb_plic.sv ====
`timescale 1ns/10ps

`include "plic_defs.svh"

module tb_plic;

    import plic_bus_pkg::*;
    import plic_irq_pkg::*;

    localparam int CLK_PERIOD  = 100;
    localparam int ACK_TIMEOUT = 20;
    localparam int RAND_ROUNDS = 4;
    localparam int RAND_TEST   = 7;

    logic                          clk;
    logic                          rst_n;
    logic                          bus_cyc;
    logic                          bus_we;
    bus_addr_t                     bus_addr;
    bus_data_t                     bus_wdata;
    logic                          plic_sel;
    bus_data_t                     bus_rdata;
    logic                          bus_ack;
    src_mask_t                     irq_src;
    logic [`PLIC_TARGET_COUNT-1:0] irq;

    integer seed         = 32'h392c_2dbc;
    int     tests_passed = 0;
    int     tests_failed = 0;
    int     test_errors  = 0;
    int     cur_test     = -1;
    string  cur_name     = "";
    logic   timed_out    = 1'b0;

    plic_top plic_top_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .bus_cyc_i   (bus_cyc),
        .bus_we_i    (bus_we),
        .bus_addr_i  (bus_addr),
        .bus_wdata_i (bus_wdata),
        .plic_sel_i  (plic_sel),
        .bus_rdata_o (bus_rdata),
        .bus_ack_o   (bus_ack),
        .irq_src_i   (irq_src),
        .irq_o       (irq)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // ------------------------------------------------------------
    // Bus master and checks
    // ------------------------------------------------------------
    // Request starts on a falling edge and is held until ack is seen
    task automatic bus_access(input logic we, input bus_addr_t addr,
                              input bus_data_t wdata, output bus_data_t rdata);
        int waited;

        waited = 0;
        rdata  = '0;
        @(negedge clk);
        bus_cyc   = 1'b1;
        plic_sel  = 1'b1;
        bus_we    = we;
        bus_addr  = addr;
        bus_wdata = wdata;
        @(negedge clk);
        while (!bus_ack && waited < ACK_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!bus_ack) begin
            $display("timeout: no bus ack within %0d cycles for address %h", ACK_TIMEOUT, addr);
            timed_out = 1'b1;
            test_errors++;
        end else begin
            rdata = bus_rdata;
        end
        bus_cyc  = 1'b0;
        plic_sel = 1'b0;
        bus_we   = 1'b0;
    endtask

    task automatic check_value(input string sig, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("error: time %0t, %s expected %h actual %h", $time, sig, expected, actual);
            test_errors++;
        end
    endtask

    task automatic close_test();
        if (test_errors == 0) begin
            $display("test %0d %s: ok", cur_test, cur_name);
            tests_passed++;
        end else begin
            $display("test %0d %s: %0d errors", cur_test, cur_name, test_errors);
            tests_failed++;
        end
        test_errors = 0;
    endtask

    // One line of the stimulus file
    task automatic apply_step(input logic [7:0] op, input logic [31:0] addr,
                              input logic [31:0] data, input logic [31:0] expected);
        bus_data_t rdata;

        case (op)
            "W": bus_access(1'b1, addr, data, rdata);
            "R": begin
                bus_access(1'b0, addr, '0, rdata);
                if (!timed_out) begin
                    check_value("bus_rdata_o", expected, rdata);
                end
            end
            "S": begin
                @(negedge clk);
                irq_src = data[`PLIC_SOURCE_COUNT-1:0];
            end
            "I": begin
                // Pending state settles on the edge before this one
                @(negedge clk);
                check_value("irq_o", expected, 32'(irq));
            end
            default: begin
                $display("unknown operation %s in stimulus file", op);
                test_errors++;
            end
        endcase
    endtask

    // ------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------
    initial begin
        int               fd;
        int               n;
        int               test_num;
        logic             done;
        logic [7:0]       op;
        logic [31:0]      addr;
        logic [31:0]      data;
        logic [31:0]      expected;
        logic [8*24-1:0]  name;
        logic [8*128-1:0] skip_line;
        logic [31:0]      value;
        bus_data_t        rdata;

        rst_n     = 1'b0;
        bus_cyc   = 1'b0;
        bus_we    = 1'b0;
        bus_addr  = '0;
        bus_wdata = '0;
        plic_sel  = 1'b0;
        irq_src   = '0;
        done      = 1'b0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;

        fd = $fopen("tests/plic_stimulus.txt", "r");
        if (fd == 0) begin
            $display("cannot open stimulus file tests/plic_stimulus.txt");
            tests_failed++;
            done = 1'b1;
        end

        while (!done && !timed_out) begin
            n = $fscanf(fd, "%s", op);
            if (n != 1) begin
                done = 1'b1;
            end else if (op == "#") begin
                n = $fgets(skip_line, fd);
            end else begin
                n = $fscanf(fd, "%h %h %h %d %s", addr, data, expected, test_num, name);
                if (n != 5) begin
                    $display("malformed stimulus line after operation %s", op);
                    tests_failed++;
                    done = 1'b1;
                end else begin
                    if (test_num != cur_test) begin
                        if (cur_test >= 0) begin
                            close_test();
                        end
                        cur_test = test_num;
                        cur_name = $sformatf("%0s", name);
                    end
                    apply_step(op, addr, data, expected);
                end
            end
        end
        if (cur_test >= 0) begin
            close_test();
        end
        if (fd != 0) begin
            $fclose(fd);
        end

        // Random priorities, readback keeps the low field bits only
        if (!timed_out) begin
            cur_test = RAND_TEST;
            cur_name = "random_prio";
            for (int i = 0; i < RAND_ROUNDS && !timed_out; i++) begin
                for (int s = 1; s <= `PLIC_SOURCE_COUNT && !timed_out; s++) begin
                    value = $random(seed);
                    bus_access(1'b1, bus_addr_t'(`PLIC_OFS_PRIO_BASE + 4 * s), value, rdata);
                    bus_access(1'b0, bus_addr_t'(`PLIC_OFS_PRIO_BASE + 4 * s), '0, rdata);
                    if (!timed_out) begin
                        check_value("bus_rdata_o", value & ((1 << `PLIC_PRIO_WIDTH) - 1), rdata);
                    end
                end
            end
            close_test();
        end

        $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && !timed_out) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== tests/plic_stimulus.txt ====
# op addr data expected test name, addr data expected in hex, test in decimal
# W write, R read and compare, S set source levels from data, I compare irq_o
R 00000004 0 0 1 reset
R 00001000 0 0 1 reset
R 00201000 0 0 1 reset
I 0 0 0 1 reset
W 00000000 7 0 1 reset
R 00000000 0 0 1 reset
W 00000004 ff 0 2 readback
W 0c000008 3 0 2 readback
W 00002000 ffffffff 0 2 readback
W 00201000 5 0 2 readback
R 00000004 0 7 2 readback
R 00000008 0 3 2 readback
R 00002000 0 6 2 readback
R 00201000 0 5 2 readback
S 0 3 0 3 pending
R 00001000 0 6 3 pending
I 0 0 1 4 select
W 00200000 7 0 4 select
R 00200004 0 0 4 select
I 0 0 0 4 select
W 00200000 0 0 4 select
W 00000008 7 0 4 select
R 00200004 0 1 4 select
W 00200004 1 0 4 select
W 00000004 2 0 4 select
R 00200004 0 2 4 select
R 00001000 0 2 5 claim_complete
R 00200004 0 1 5 claim_complete
R 00200004 0 0 5 claim_complete
W 00200004 1 0 5 claim_complete
R 00001000 0 2 5 claim_complete
W 00200004 2 0 5 claim_complete
R 00001000 0 6 5 claim_complete
W 00002000 0 0 6 target_mask
W 00002080 4 0 6 target_mask
I 0 0 2 6 target_mask
W 00201000 7 0 6 target_mask
I 0 0 0 6 target_mask

// ==== tb.f ====
+incdir+hdl
hdl/plic_bus_pkg.sv
hdl/plic_irq_pkg.sv
hdl/plic_regs.sv
hdl/plic_gateway.sv
hdl/plic_target.sv
hdl/plic_top.sv
tests/tb_plic.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_plic
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Testbench failed" $(LOG) || ! grep -q "Testbench passed" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
